//--- filelist.f
+incdir+verification
rtl/valu_pkg.sv
rtl/valu_issue_if.sv
rtl/operand_capture.sv
rtl/lane_alu.sv
rtl/lane_shifter.sv
rtl/lane_multiplier.sv
rtl/result_stage.sv
rtl/valu_top.sv
verification/valu_tb.sv

//--- rtl/lane_alu.sv
`timescale 1ns/1ps

module lane_alu (
	valu_issue_if.sink issue,
	output valu_pkg::word_t alu_result
);
	import valu_pkg::*;

	logic is_sub;
	word_t addsub;
	logic carry_out [MAX_LANES];

	assign is_sub = (issue.func == VSUB);

	// One adder per 8-bit granule with the carry cut at every lane boundary
	for (genvar gl = 0; gl < MAX_LANES; gl++) begin : g_lane
		lane8_t a_chunk;
		lane8_t b_eff;
		lane8_t sum_chunk;
		logic carry_in;

		assign a_chunk = issue.opa[gl*LANE_MIN_BITS +: LANE_MIN_BITS];
		assign b_eff = is_sub ? ~issue.opb[gl*LANE_MIN_BITS +: LANE_MIN_BITS]
			: issue.opb[gl*LANE_MIN_BITS +: LANE_MIN_BITS];
		// Subtract injects the +1 of the two's complement at each lane end
		if (gl == MAX_LANES - 1) begin : g_word_end
			// Last granule of the word ends a lane at every width
			assign carry_in = is_sub;
		end else begin : g_inner
			logic lane_end;

			// Least significant granule of its lane at the current width
			assign lane_end = (((gl + 1) & ((1 << issue.width) - 1)) == 0);
			assign carry_in = lane_end ? is_sub : carry_out[gl+1];
		end
		assign {carry_out[gl], sum_chunk} = {1'b0, a_chunk} + {1'b0, b_eff} + {8'd0, carry_in};
		assign addsub[gl*LANE_MIN_BITS +: LANE_MIN_BITS] = sum_chunk;
	end

	// Bitwise ops ignore the lane width
	always_comb begin
		case (issue.func)
			VAND: alu_result = issue.opa & issue.opb;
			VOR: alu_result = issue.opa | issue.opb;
			VXOR: alu_result = issue.opa ^ issue.opb;
			VNOT: alu_result = ~issue.opa;
			VMOV: alu_result = issue.opa;
			VADD, VSUB: alu_result = addsub;
			default: alu_result = '0;
		endcase
	end

endmodule

//--- rtl/lane_multiplier.sv
`timescale 1ns/1ps

module lane_multiplier (
	valu_issue_if.sink issue,
	output valu_pkg::word_t mul_result
);
	import valu_pkg::*;

	logic is_odd;
	// Widths 8, 16 and 32 only
	word_t mul_w [NUM_WIDTHS-1];

	assign is_odd = (issue.func == VMULOU);

	for (genvar gw = 0; gw < NUM_WIDTHS - 1; gw++) begin : g_width
		// Each pair of source lanes yields one double-width product lane
		for (genvar gp = 0; gp < (MAX_LANES >> (gw + 1)); gp++) begin : g_pair
			logic [lane_bits(gw)-1:0] a_sel;
			logic [lane_bits(gw)-1:0] b_sel;

			// Even is the first lane of the pair, odd the second
			assign a_sel = is_odd
				? issue.opa[gp*2*lane_bits(gw) + lane_bits(gw) +: lane_bits(gw)]
				: issue.opa[gp*2*lane_bits(gw) +: lane_bits(gw)];
			assign b_sel = is_odd
				? issue.opb[gp*2*lane_bits(gw) + lane_bits(gw) +: lane_bits(gw)]
				: issue.opb[gp*2*lane_bits(gw) +: lane_bits(gw)];

			assign mul_w[gw][gp*2*lane_bits(gw) +: 2*lane_bits(gw)] = a_sel * b_sel;
		end
	end

	always_comb begin
		case (issue.width)
			W8: mul_result = mul_w[0];
			W16: mul_result = mul_w[1];
			W32: mul_result = mul_w[2];
			// Never valid here, filtered at capture
			default: mul_result = '0;
		endcase
	end

endmodule

//--- rtl/lane_shifter.sv
`timescale 1ns/1ps

module lane_shifter (
	valu_issue_if.sink issue,
	output valu_pkg::word_t shift_result
);
	import valu_pkg::*;

	// One full-word result per lane width
	word_t shift_w [NUM_WIDTHS];

	for (genvar gw = 0; gw < NUM_WIDTHS; gw++) begin : g_width
		for (genvar gl = 0; gl < (MAX_LANES >> gw); gl++) begin : g_lane
			logic [lane_bits(gw)-1:0] a_lane;
			logic [lane_shamt_bits(gw)-1:0] amt;
			logic [lane_bits(gw)-1:0] lane_res;

			assign a_lane = issue.opa[gl*lane_bits(gw) +: lane_bits(gw)];

			// Shift amount sits in the low bits, which are at the right end of the B lane
			assign amt = issue.opb[(gl+1)*lane_bits(gw) - lane_shamt_bits(gw)
				+: lane_shamt_bits(gw)];

			always_comb begin
				case (issue.func)
					VSLL: lane_res = a_lane << amt;
					VSRL: lane_res = a_lane >> amt;
					// Sign bit refills the vacated upper bits
					VSRA: lane_res = $signed(a_lane) >>> amt;
					VRTTH: begin
						lane_res = {a_lane[lane_bits(gw)/2-1:0],
							a_lane[lane_bits(gw)-1:lane_bits(gw)/2]};
					end
					default: lane_res = '0;
				endcase
			end

			assign shift_w[gw][gl*lane_bits(gw) +: lane_bits(gw)] = lane_res;
		end
	end

	always_comb begin
		case (issue.width)
			W8: shift_result = shift_w[0];
			W16: shift_result = shift_w[1];
			W32: shift_result = shift_w[2];
			W64: shift_result = shift_w[3];
			default: shift_result = '0;
		endcase
	end

endmodule

//--- rtl/operand_capture.sv
`timescale 1ns/1ps

module operand_capture (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input valu_pkg::valu_opcode_e opcode,
	input logic [5:0] func,
	input valu_pkg::lane_width_e width,
	input valu_pkg::word_t opa,
	input valu_pkg::word_t opb,
	valu_issue_if.source issue
);
	import valu_pkg::*;

	logic func_kept;
	logic is_mul;
	logic accept;

	// Only functions with a unit behind them
	always_comb begin
		case (func)
			VAND, VOR, VXOR, VNOT, VMOV: func_kept = 1'b1;
			VADD, VSUB: func_kept = 1'b1;
			VMULEU, VMULOU: func_kept = 1'b1;
			VSLL, VSRL, VSRA, VRTTH: func_kept = 1'b1;
			// VNOP has no result to return
			VNOP: func_kept = 1'b0;
			default: func_kept = 1'b0;
		endcase
	end

	assign is_mul = (func == VMULEU) || (func == VMULOU);

	// No 64x64 product lane exists, so W64 multiplies are dropped
	assign accept = in_valid && (opcode == R_ALU) && func_kept && !(is_mul && width == W64);

	always_ff @(posedge clk) begin
		if (rst) begin
			issue.valid <= 1'b0;
		end else begin
			issue.valid <= accept;
		end
	end

	// Payload registers
	always_ff @(posedge clk) begin
		issue.func <= valu_func_e'(func);
		issue.width <= width;
		issue.opa <= opa;
		issue.opb <= opb;
	end

	a_no_wide_mul: assert property (@(posedge clk) disable iff (rst)
		issue.valid |-> !((issue.func == VMULEU || issue.func == VMULOU) && issue.width == W64))
		else $error("multiply at W64 issued to the lane units");

endmodule

//--- rtl/result_stage.sv
`timescale 1ns/1ps

module result_stage (
	input logic clk,
	input logic rst,
	valu_issue_if.sink issue,
	input valu_pkg::word_t alu_result,
	input valu_pkg::word_t shift_result,
	input valu_pkg::word_t mul_result,
	output logic out_valid,
	output valu_pkg::word_t out_result
);
	import valu_pkg::*;

	word_t sel_result;

	// Pick the unit by function group
	always_comb begin
		case (issue.func)
			VSLL, VSRL, VSRA, VRTTH: sel_result = shift_result;
			VMULEU, VMULOU: sel_result = mul_result;
			default: sel_result = alu_result;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= issue.valid;
		end
	end

	// Result holds between valid items
	always_ff @(posedge clk) begin
		if (rst) begin
			out_result <= '0;
		end else if (issue.valid) begin
			out_result <= sel_result;
		end
	end

	a_valid_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(out_valid))
		else $error("out_valid is unknown");

endmodule

//--- rtl/valu_issue_if.sv
`timescale 1ns/1ps

interface valu_issue_if;
	import valu_pkg::*;

	// Qualifies one decoded instruction per cycle
	logic valid;
	valu_func_e func;
	lane_width_e width;
	word_t opa;
	word_t opb;

	modport source (
		output valid, func, width, opa, opb
	);

	// Lane units read everything but valid
	modport sink (
		input valid, func, width, opa, opb
	);

endinterface

//--- rtl/valu_pkg.sv
package valu_pkg;

	// Datapath geometry
	localparam int WORD_BITS = 64;
	localparam int MAX_LANES = 8;
	localparam int LANE_MIN_BITS = WORD_BITS / MAX_LANES;
	localparam int NUM_WIDTHS = 4;

	// Bit 0 is the most significant bit of the word
	typedef logic [0:WORD_BITS-1] word_t;

	// Narrowest lane, also the carry-chain granule of the adder
	typedef logic [LANE_MIN_BITS-1:0] lane8_t;

	typedef enum logic [5:0] {
		R_ALU     = 6'b101010,
		LOAD      = 6'b100000,
		STORE     = 6'b100001,
		BRANCH_EZ = 6'b100010,
		BRANCH_NZ = 6'b100011,
		NOP       = 6'b111100
	} valu_opcode_e;

	typedef enum logic [5:0] {
		VNOP   = 6'b000000,
		VAND   = 6'b000001,
		VOR    = 6'b000010,
		VXOR   = 6'b000011,
		VNOT   = 6'b000100,
		VMOV   = 6'b000101,
		VADD   = 6'b000110,
		VSUB   = 6'b000111,
		VMULEU = 6'b001000,
		VMULOU = 6'b001001,
		VSLL   = 6'b001010,
		VSRL   = 6'b001011,
		VSRA   = 6'b001100,
		VRTTH  = 6'b001101
	} valu_func_e;

	typedef enum logic [1:0] {
		W8  = 2'b00,
		W16 = 2'b01,
		W32 = 2'b10,
		W64 = 2'b11
	} lane_width_e;

	// Lane size in bits for width index 0..3
	function automatic int lane_bits(int wi);
		return LANE_MIN_BITS << wi;
	endfunction

	// Shift amount field size for width index 0..3
	function automatic int lane_shamt_bits(int wi);
		return $clog2(lane_bits(wi));
	endfunction

endpackage

//--- rtl/valu_top.sv
`timescale 1ns/1ps

module valu_top (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input valu_pkg::valu_opcode_e opcode,
	input logic [5:0] func,
	input valu_pkg::lane_width_e width,
	input valu_pkg::word_t opa,
	input valu_pkg::word_t opb,
	output logic out_valid,
	output valu_pkg::word_t out_result
);
	import valu_pkg::*;

	word_t alu_result;
	word_t shift_result;
	word_t mul_result;

	valu_issue_if issue ();

	// Stage 1, decode and operand registers
	operand_capture capture0 (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.opcode   (opcode),
		.func     (func),
		.width    (width),
		.opa      (opa),
		.opb      (opb),
		.issue    (issue.source)
	);

	// Execution units work in parallel off the same issue
	lane_alu alu0 (
		.issue      (issue.sink),
		.alu_result (alu_result)
	);

	lane_shifter shifter0 (
		.issue        (issue.sink),
		.shift_result (shift_result)
	);

	lane_multiplier mult0 (
		.issue      (issue.sink),
		.mul_result (mul_result)
	);

	// Stage 2, result select and output registers
	result_stage result0 (
		.clk          (clk),
		.rst          (rst),
		.issue        (issue.sink),
		.alu_result   (alu_result),
		.shift_result (shift_result),
		.mul_result   (mul_result),
		.out_valid    (out_valid),
		.out_result   (out_result)
	);

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -f filelist.f --top-module valu_tb -o valu_sim \
	&& ./obj_dir/valu_sim | grep "TB PASSED" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- verification/valu_tb_tasks.svh
// Galois LFSR, one call per random bit
function automatic logic lfsr_bit();
	logic out;
	out = lfsr_state[0];
	lfsr_state = lfsr_state >> 1;
	if (out) begin
		lfsr_state = lfsr_state ^ 32'hd000_0001;
	end
	return out;
endfunction

function automatic int rand_bits(int n);
	int val;
	val = 0;
	for (int i = 0; i < n; i++) begin
		val = (val << 1) | int'(lfsr_bit());
	end
	return val;
endfunction

function automatic word_t rand_word();
	logic [63:0] val;
	val = '0;
	for (int i = 0; i < 64; i++) begin
		val = {val[62:0], lfsr_bit()};
	end
	return val;
endfunction

// Whether an instruction should ever reach the output
function automatic logic should_issue(valu_opcode_e op, logic [5:0] fn, lane_width_e wd);
	logic known;
	logic is_mul;
	known = fn inside {VAND, VOR, VXOR, VNOT, VMOV, VADD, VSUB, VMULEU, VMULOU,
		VSLL, VSRL, VSRA, VRTTH};
	is_mul = (fn == VMULEU) || (fn == VMULOU);
	return (op == R_ALU) && known && !(is_mul && wd == W64);
endfunction

// Lane j counts from the least significant end of the word
function automatic word_t expected_result(valu_func_e f, lane_width_e wd, word_t a_in,
	word_t b_in);
	logic [63:0] a;
	logic [63:0] b;
	logic [63:0] mask;
	logic [63:0] la;
	logic [63:0] lb;
	logic [63:0] r;
	logic [63:0] res;
	int w;
	int amt;
	int up;
	a = a_in;
	b = b_in;
	w = 8 << int'(wd);
	mask = (w == 64) ? {64{1'b1}} : ((64'd1 << w) - 64'd1);
	res = '0;
	case (f)
		VAND: res = a & b;
		VOR: res = a | b;
		VXOR: res = a ^ b;
		VNOT: res = ~a;
		VMOV: res = a;
		VMULEU, VMULOU: begin
			// Even takes the more significant lane of each pair
			up = (f == VMULEU) ? w : 0;
			for (int p = 0; p < 32 / w; p++) begin
				la = (a >> (2 * p * w + up)) & mask;
				lb = (b >> (2 * p * w + up)) & mask;
				res = res | ((la * lb) << (2 * p * w));
			end
		end
		VADD, VSUB, VSLL, VSRL, VSRA, VRTTH: begin
			for (int j = 0; j < 64 / w; j++) begin
				la = (a >> (j * w)) & mask;
				lb = (b >> (j * w)) & mask;
				amt = int'(lb & 64'(w - 1));
				case (f)
					VADD: r = la + lb;
					VSUB: r = la - lb;
					VSLL: r = la << amt;
					VSRL: r = la >> amt;
					VSRA: r = la[w-1] ? ((la >> amt) | ~(mask >> amt)) : (la >> amt);
					default: r = (la >> (w / 2)) | (la << (w / 2));
				endcase
				res = res | ((r & mask) << (j * w));
			end
		end
		default: res = '0;
	endcase
	return res;
endfunction

task automatic check_word(string name, word_t exp, word_t act);
	if (act !== exp) begin
		$display("ERROR %s: expected %h, actual %h", name, exp, act);
		error_count++;
	end
endtask

task automatic check_valid(string name, logic exp, logic act);
	if (act !== exp) begin
		$display("ERROR %s out_valid: expected %b, actual %b", name, exp, act);
		error_count++;
	end
endtask

// Drives one instruction and queues its result if it is kept
task automatic send(string name, valu_opcode_e op, logic [5:0] fn, lane_width_e wd,
	word_t a, word_t b);
	@(posedge clk);
	in_valid <= 1'b1;
	opcode <= op;
	func <= fn;
	width <= wd;
	opa <= a;
	opb <= b;
	if (should_issue(op, fn, wd)) begin
		exp_q.push_back(expected_result(valu_func_e'(fn), wd, a, b));
		due_q.push_back(cyc + 3);
		name_q.push_back(name);
	end
endtask

//--- verification/valu_tb.sv
`timescale 1ns/1ps

module valu_tb;
	import valu_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int NUM_TESTS = 6;
	// Codes of functions that the ALU no longer implements
	localparam logic [5:0] FUNC_VDIV = 6'b001110;
	localparam logic [5:0] FUNC_VSQRT = 6'b010010;

	logic clk;
	logic rst;
	logic in_valid;
	valu_opcode_e opcode;
	logic [5:0] func;
	lane_width_e width;
	word_t opa;
	word_t opb;
	logic out_valid;
	word_t out_result;

	logic [31:0] lfsr_state = 32'h73f9947b;
	int cyc = 0;
	int error_count = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	bit monitor_on = 1'b0;
	string cur_test = "reset";
	word_t last_result;
	word_t exp_q[$];
	int due_q[$];
	string name_q[$];

	`include "valu_tb_tasks.svh"

	valu_top dut0 (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.opcode     (opcode),
		.func       (func),
		.width      (width),
		.opa        (opa),
		.opb        (opb),
		.out_valid  (out_valid),
		.out_result (out_result)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(NUM_TESTS * 64 * CLK_PERIOD);
		$display("Timeout: the tests did not finish in the allotted time");
		$display("TB FAILED");
		$finish;
	end

	// Every cycle either the oldest result is due or the output must hold
	task automatic check_output();
		if (due_q.size() > 0 && due_q[0] == cyc) begin
			check_valid(name_q[0], 1'b1, out_valid);
			check_word(name_q[0], exp_q[0], out_result);
			last_result = exp_q[0];
			void'(due_q.pop_front());
			void'(exp_q.pop_front());
			void'(name_q.pop_front());
		end else begin
			check_valid(cur_test, 1'b0, out_valid);
			check_word({cur_test, " hold"}, last_result, out_result);
		end
	endtask

	always @(negedge clk) begin
		cyc = cyc + 1;
		if (monitor_on) begin
			check_output();
		end
	end

	task automatic apply_reset();
		monitor_on = 1'b0;
		rst <= 1'b1;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		in_valid <= 1'b0;
		due_q.delete();
		exp_q.delete();
		name_q.delete();
		last_result = '0;
		@(negedge clk);
		check_valid("reset", 1'b0, out_valid);
		check_word("reset", '0, out_result);
		monitor_on = 1'b1;
	endtask

	// Stops issuing and waits for the queued results
	task automatic drain();
		int waited;
		waited = 0;
		@(posedge clk);
		in_valid <= 1'b0;
		while (due_q.size() > 0 && waited < 16) begin
			@(negedge clk);
			waited++;
		end
		if (due_q.size() > 0) begin
			$display("Test %s: %0d results never appeared", cur_test, due_q.size());
			error_count++;
			due_q.delete();
			exp_q.delete();
			name_q.delete();
		end
		repeat (3) @(negedge clk);
	endtask

	task automatic finish_test(string name, int start);
		if (error_count == start) begin
			$display("Test %s: pass", name);
			tests_passed++;
		end else begin
			$display("Test %s: fail with %0d errors", name, error_count - start);
			tests_failed++;
		end
	endtask

	task automatic test_bitwise();
		int start;
		valu_func_e ops[5] = '{VAND, VOR, VXOR, VNOT, VMOV};
		start = error_count;
		cur_test = "bitwise";
		for (int i = 0; i < 4; i++) begin
			foreach (ops[k]) begin
				send("bitwise", R_ALU, ops[k], lane_width_e'(i), rand_word(), rand_word());
			end
		end
		drain();
		finish_test("bitwise", start);
	endtask

	task automatic test_addsub();
		int start;
		lane_width_e wd;
		start = error_count;
		cur_test = "addsub";
		for (int i = 0; i < 4; i++) begin
			wd = lane_width_e'(i);
			send("add", R_ALU, VADD, wd, rand_word(), rand_word());
			send("sub", R_ALU, VSUB, wd, rand_word(), rand_word());
			// Carry and borrow out of every lane
			send("add ones", R_ALU, VADD, wd, '1, '1);
			send("sub borrow", R_ALU, VSUB, wd, '0, '1);
		end
		drain();
		finish_test("addsub", start);
	endtask

	task automatic test_shift();
		int start;
		valu_func_e ops[4] = '{VSLL, VSRL, VSRA, VRTTH};
		start = error_count;
		cur_test = "shift";
		for (int i = 0; i < 4; i++) begin
			foreach (ops[k]) begin
				send("shift", R_ALU, ops[k], lane_width_e'(i), rand_word(), rand_word());
			end
			// Sign bit set in every lane at every width
			send("sra negative", R_ALU, VSRA, lane_width_e'(i), 64'hf0e1_d2c3_b4a5_9687,
				rand_word());
		end
		drain();
		finish_test("shift", start);
	endtask

	task automatic test_multiply();
		int start;
		lane_width_e wd;
		start = error_count;
		cur_test = "multiply";
		for (int i = 0; i < 3; i++) begin
			wd = lane_width_e'(i);
			send("muleu", R_ALU, VMULEU, wd, rand_word(), rand_word());
			send("mulou", R_ALU, VMULOU, wd, rand_word(), rand_word());
			send("muleu max", R_ALU, VMULEU, wd, '1, '1);
			send("mulou max", R_ALU, VMULOU, wd, '1, '1);
		end
		drain();
		finish_test("multiply", start);
	endtask

	task automatic test_dropped();
		int start;
		start = error_count;
		cur_test = "dropped";
		// A known result that the dropped items must leave in place
		send("dropped setup", R_ALU, VXOR, W8, rand_word(), rand_word());
		send("load", LOAD, VADD, W8, rand_word(), rand_word());
		send("nop", NOP, VAND, W16, rand_word(), rand_word());
		send("vdiv", R_ALU, FUNC_VDIV, W32, rand_word(), rand_word());
		send("vsqrt", R_ALU, FUNC_VSQRT, W8, rand_word(), rand_word());
		send("muleu w64", R_ALU, VMULEU, W64, rand_word(), rand_word());
		drain();
		finish_test("dropped", start);
	endtask

	task automatic test_stream();
		int start;
		valu_func_e fn;
		lane_width_e wd;
		valu_func_e kept[13] = '{VAND, VOR, VXOR, VNOT, VMOV, VADD, VSUB, VMULEU, VMULOU,
			VSLL, VSRL, VSRA, VRTTH};
		start = error_count;
		cur_test = "stream";
		// A kept instruction held on the inputs through reset must not come out
		@(posedge clk);
		in_valid <= 1'b1;
		opcode <= R_ALU;
		func <= VADD;
		width <= W8;
		opa <= rand_word();
		opb <= rand_word();
		apply_reset();
		for (int i = 0; i < 8; i++) begin
			fn = kept[rand_bits(4) % 13];
			wd = lane_width_e'(rand_bits(2));
			if ((fn == VMULEU || fn == VMULOU) && wd == W64) begin
				wd = W32;
			end
			send("stream", R_ALU, fn, wd, rand_word(), rand_word());
			if (i % 3 == 1) begin
				send("stream nop", NOP, VADD, W8, rand_word(), rand_word());
			end else if (i % 3 == 2) begin
				send("stream vdiv", R_ALU, FUNC_VDIV, W16, rand_word(), rand_word());
			end
		end
		drain();
		finish_test("stream", start);
	endtask

	initial begin
		rst <= 1'b1;
		in_valid <= 1'b0;
		opcode <= NOP;
		func <= '0;
		width <= W8;
		opa <= '0;
		opb <= '0;
		apply_reset();
		test_bitwise();
		test_addsub();
		test_shift();
		test_multiply();
		test_dropped();
		test_stream();
		$display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && error_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule
